/* verilog/lsu_macros.svh */
// address map and width constants for the load/store fabric
// include wherever port widths or register offsets are needed

`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

////////////////////
// bus widths
////////////////////

// byte address width, half memory and half peripherals
`define LSU_DAW 15
// data width and byte enable width
`define LSU_DDW 32
`define LSU_DBW (`LSU_DDW/8)
// memory word address, 4096 words
`define LSU_MAW 12

////////////////////
// address decode
////////////////////

// top address bit selects the peripheral region
`define LSU_RGN_BIT 14
// inside the peripheral region, set for the uart slot
`define LSU_PSEL_BIT 6

////////////////////
// gpio
////////////////////

`define LSU_GPIO_W 32
// register word indices
`define LSU_GPIO_OUT 0
`define LSU_GPIO_OEN 1
`define LSU_GPIO_IN  2

`endif

/* verilog/lsu_pkg.sv */
// shared data types of the load/store fabric
// compile before any module of the fabric

`default_nettype none

`include "lsu_macros.svh"

package lsu_pkg;

  ////////////////////
  // bus words
  ////////////////////

  // one data word
  typedef logic [`LSU_DDW-1:0] data_t;

  // one enable per byte lane
  typedef logic [`LSU_DBW-1:0] ben_t;

  ////////////////////
  // byte address
  ////////////////////

  // same address word, seen from the memory side and the peripheral side
  typedef union packed {
    // memory view
    struct packed {
      logic                          rgn;
      logic [`LSU_MAW-1:0]           idx;
      logic [$clog2(`LSU_DBW)-1:0]   off;
    } mem;
    // peripheral view
    struct packed {
      logic                                   rgn;
      logic [`LSU_RGN_BIT-`LSU_PSEL_BIT-2:0]  rsv;
      logic                                   psel;
      logic [`LSU_PSEL_BIT-3:0]               idx;
      logic [$clog2(`LSU_DBW)-1:0]            off;
    } per;
  } lsu_adr_u;

endpackage : lsu_pkg

`default_nettype wire

/* verilog/gpio_ctrl.sv */
// gpio controller on the zero delay peripheral bus
// output and enable registers plus synchronized pin input

`default_nettype none

`include "lsu_macros.svh"

module gpio_ctrl (
  input  logic                    clk,
  input  logic                    rst_n,
  // register bus, answers in the same cycle
  input  logic                    gpio_vld,
  input  logic                    gpio_wen,
  input  logic [3:0]              gpio_idx,
  input  lsu_pkg::ben_t           gpio_ben,
  input  lsu_pkg::data_t          gpio_wdt,
  output lsu_pkg::data_t          gpio_rdt,
  // pins
  output logic [`LSU_GPIO_W-1:0]  gpio_drive,
  output logic [`LSU_GPIO_W-1:0]  gpio_enable,
  input  logic [`LSU_GPIO_W-1:0]  gpio_pins
);

  import lsu_pkg::*;

  // merge enabled bytes of a bus write into a register
  function automatic logic [`LSU_GPIO_W-1:0] ben_merge(
    input logic [`LSU_GPIO_W-1:0] old_val,
    input data_t                  wdt,
    input ben_t                   ben
  );
    logic [`LSU_GPIO_W-1:0] res;
    res = old_val;
    for (int b = 0; b < `LSU_GPIO_W/8; b++) begin
      if (ben[b]) begin
        res[8*b +: 8] = wdt[8*b +: 8];
      end
    end
    return res;
  endfunction

  ////////////////////
  // output registers
  ////////////////////

  logic  wr;

  assign wr = gpio_vld & gpio_wen;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      gpio_drive  <= '0;
      gpio_enable <= '0;
    end else if (wr) begin
      // writes to IN and unmapped indices are dropped
      case (gpio_idx)
        `LSU_GPIO_OUT: gpio_drive  <= ben_merge(gpio_drive,  gpio_wdt, gpio_ben);
        `LSU_GPIO_OEN: gpio_enable <= ben_merge(gpio_enable, gpio_wdt, gpio_ben);
        default: ;
      endcase
    end
  end

  ////////////////////
  // input sync
  ////////////////////

  // two flops against metastability
  logic [`LSU_GPIO_W-1:0] pins_meta;
  logic [`LSU_GPIO_W-1:0] pins_sync;

  always_ff @(posedge clk) begin
    pins_meta <= gpio_pins;
    pins_sync <= pins_meta;
  end

  ////////////////////
  // read mux
  ////////////////////

  always_comb begin
    case (gpio_idx)
      `LSU_GPIO_OUT: gpio_rdt = gpio_drive;
      `LSU_GPIO_OEN: gpio_rdt = gpio_enable;
      `LSU_GPIO_IN:  gpio_rdt = pins_sync;
      // unmapped reads zero
      default:       gpio_rdt = '0;
    endcase
  end

  // write data must be driven by the master on every write
  assert property (@(posedge clk) disable iff (!rst_n) wr |-> !$isunknown(gpio_wdt));

endmodule : gpio_ctrl

`default_nettype wire

/* verilog/per_demux.sv */
// peripheral region decode, gpio in the low half and the uart slot above it
// no uart is built, so that slot answers every access with an error

`default_nettype none

`include "lsu_macros.svh"

module per_demux (
  input  logic                    clk,
  input  logic                    rst_n,
  // zero delay peripheral bus
  input  logic                    per_vld,
  input  logic                    per_wen,
  input  logic [`LSU_DAW-1:0]     per_adr,
  input  lsu_pkg::ben_t           per_ben,
  input  lsu_pkg::data_t          per_wdt,
  output lsu_pkg::data_t          per_rdt,
  output logic                    per_err,
  // gpio pins
  output logic [`LSU_GPIO_W-1:0]  gpio_drive,
  output logic [`LSU_GPIO_W-1:0]  gpio_enable,
  input  logic [`LSU_GPIO_W-1:0]  gpio_pins,
  // uart line
  output logic                    uart_txd
);

  import lsu_pkg::*;

  ////////////////////
  // decode
  ////////////////////

  lsu_adr_u  adr;
  logic      sel_uart;
  logic      gpio_vld;
  data_t     gpio_rdt;

  assign adr      = per_adr;
  // offsets 0x40..0x7f go to the uart slot
  assign sel_uart = adr.per.psel;
  assign gpio_vld = per_vld & ~sel_uart;

  ////////////////////
  // gpio
  ////////////////////

  gpio_ctrl gpio_ctrl_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .gpio_vld    (gpio_vld),
    .gpio_wen    (per_wen),
    .gpio_idx    (adr.per.idx),
    .gpio_ben    (per_ben),
    .gpio_wdt    (per_wdt),
    .gpio_rdt    (gpio_rdt),
    .gpio_drive  (gpio_drive),
    .gpio_enable (gpio_enable),
    .gpio_pins   (gpio_pins)
  );

  ////////////////////
  // response
  ////////////////////

  // uart slot reads zero and flags an error
  assign per_rdt = sel_uart ? '0 : gpio_rdt;
  assign per_err = per_vld & sel_uart;

  // serial line idle high
  assign uart_txd = 1'b1;

endmodule : per_demux

`default_nettype wire

/* verilog/per_req_register.sv */
// request register between the one cycle bus and the zero delay
// peripheral bus, peripherals see each request one cycle late

`default_nettype none

`include "lsu_macros.svh"

module per_req_register (
  input  logic                 clk,
  input  logic                 rst_n,
  // request in
  input  logic                 pb_vld,
  input  logic                 pb_wen,
  input  logic [`LSU_DAW-1:0]  pb_adr,
  input  lsu_pkg::ben_t        pb_ben,
  input  lsu_pkg::data_t       pb_wdt,
  // request out
  output logic                 per_vld,
  output logic                 per_wen,
  output logic [`LSU_DAW-1:0]  per_adr,
  output lsu_pkg::ben_t        per_ben,
  output lsu_pkg::data_t       per_wdt
);

  ////////////////////
  // valid
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      per_vld <= 1'b0;
    end else begin
      per_vld <= pb_vld;
    end
  end

  ////////////////////
  // payload
  ////////////////////

  // only load on a transfer, holds otherwise
  always_ff @(posedge clk) begin
    if (pb_vld) begin
      per_wen <= pb_wen;
      per_adr <= pb_adr;
      per_ben <= pb_ben;
      per_wdt <= pb_wdt;
    end
  end

endmodule : per_req_register

`default_nettype wire

/* verilog/data_mem.sv */
// single port data ram with byte lane writes
// read data shows up one cycle after the request, old data on a write

`default_nettype none

`include "lsu_macros.svh"

module data_mem (
  input  logic                 clk,
  input  logic                 mem_vld,
  input  logic                 mem_wen,
  input  logic [`LSU_MAW-1:0]  mem_adr,
  input  lsu_pkg::ben_t        mem_ben,
  input  lsu_pkg::data_t       mem_wdt,
  output lsu_pkg::data_t       mem_rdt
);

  import lsu_pkg::*;

  ////////////////////
  // storage
  ////////////////////

  // one word per address, no init file
  data_t mem [0:2**`LSU_MAW-1];

  // registered read on every access, old word on a write
  always_ff @(posedge clk) begin
    if (mem_vld) begin
      mem_rdt <= mem[mem_adr];
      // byte lanes written separately
      if (mem_wen) begin
        for (int b = 0; b < `LSU_DBW; b++) begin
          if (mem_ben[b]) begin
            mem[mem_adr][8*b +: 8] <= mem_wdt[8*b +: 8];
          end
        end
      end
    end
  end

endmodule : data_mem

`default_nettype wire

/* verilog/lsu_demux.sv */
// splits the load/store bus into data memory and peripheral region
// and picks the matching response one cycle after the request

`default_nettype none

`include "lsu_macros.svh"

module lsu_demux (
  input  logic                 clk,
  input  logic                 rst_n,
  // load/store bus from the master
  input  logic                 bus_vld,
  input  logic                 bus_wen,
  input  logic [`LSU_DAW-1:0]  bus_adr,
  input  lsu_pkg::ben_t        bus_ben,
  input  lsu_pkg::data_t       bus_wdt,
  output lsu_pkg::data_t       bus_rdt,
  output logic                 bus_err,
  // data memory
  output logic                 mem_vld,
  output logic                 mem_wen,
  output logic [`LSU_MAW-1:0]  mem_adr,
  output lsu_pkg::ben_t        mem_ben,
  output lsu_pkg::data_t       mem_wdt,
  input  lsu_pkg::data_t       mem_rdt,
  // peripheral region
  output logic                 pb_vld,
  output logic                 pb_wen,
  output logic [`LSU_DAW-1:0]  pb_adr,
  output lsu_pkg::ben_t        pb_ben,
  output lsu_pkg::data_t       pb_wdt,
  input  lsu_pkg::data_t       per_rdt,
  input  logic                 per_err
);

  import lsu_pkg::*;

  ////////////////////
  // request decode
  ////////////////////

  lsu_adr_u  adr;
  logic      sel_per;

  assign adr     = bus_adr;
  // region bit, high half is peripherals
  assign sel_per = adr.mem.rgn;

  // memory gets the word index only
  assign mem_vld = bus_vld & ~sel_per;
  assign mem_wen = bus_wen;
  assign mem_adr = adr.mem.idx;
  assign mem_ben = bus_ben;
  assign mem_wdt = bus_wdt;

  // peripherals keep the full byte address
  assign pb_vld  = bus_vld & sel_per;
  assign pb_wen  = bus_wen;
  assign pb_adr  = bus_adr;
  assign pb_ben  = bus_ben;
  assign pb_wdt  = bus_wdt;

  ////////////////////
  // response select
  ////////////////////

  // which side owns the response in the next cycle
  logic  rsp_vld;
  logic  rsp_per;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp_vld <= 1'b0;
      rsp_per <= 1'b0;
    end else begin
      rsp_vld <= bus_vld;
      // hold the last owner while idle
      if (bus_vld) begin
        rsp_per <= sel_per;
      end
    end
  end

  assign bus_rdt = rsp_per ? per_rdt : mem_rdt;
  // memory never errors, idle cycles show no error
  assign bus_err = rsp_vld & rsp_per & per_err;

  ////////////////////
  // checks
  ////////////////////

  // one target per transfer
  assert property (@(posedge clk) disable iff (!rst_n) !(mem_vld && pb_vld));

  // an error seen here always belongs to a peripheral request one cycle back
  assert property (@(posedge clk) disable iff (!rst_n) per_err |-> rsp_vld && rsp_per);

endmodule : lsu_demux

`default_nettype wire

/* verilog/lsu_fabric_top.sv */
// data side of the soc, load/store bus in, memory and peripherals behind it
// response delay on the outside bus is one cycle for every address

`default_nettype none

`include "lsu_macros.svh"

module lsu_fabric_top (
  // system
  input  logic                    clk,
  input  logic                    rst_n,
  // load/store bus
  input  logic                    bus_vld,
  input  logic                    bus_wen,
  input  logic [`LSU_DAW-1:0]     bus_adr,
  input  lsu_pkg::ben_t           bus_ben,
  input  lsu_pkg::data_t          bus_wdt,
  output lsu_pkg::data_t          bus_rdt,
  output logic                    bus_err,
  // gpio pins
  output logic [`LSU_GPIO_W-1:0]  gpio_drive,
  output logic [`LSU_GPIO_W-1:0]  gpio_enable,
  input  logic [`LSU_GPIO_W-1:0]  gpio_pins,
  // uart pins, no controller behind them
  output logic                    uart_txd,
  input  logic                    uart_rxd
);

  import lsu_pkg::*;

  ////////////////////
  // local links
  ////////////////////

  // memory side, one cycle delay
  logic                 mem_vld;
  logic                 mem_wen;
  logic [`LSU_MAW-1:0]  mem_adr;
  ben_t                 mem_ben;
  data_t                mem_wdt;
  data_t                mem_rdt;

  // peripheral side before the request register
  logic                 pb_vld;
  logic                 pb_wen;
  logic [`LSU_DAW-1:0]  pb_adr;
  ben_t                 pb_ben;
  data_t                pb_wdt;

  // zero delay peripheral bus
  logic                 per_vld;
  logic                 per_wen;
  logic [`LSU_DAW-1:0]  per_adr;
  ben_t                 per_ben;
  data_t                per_wdt;
  data_t                per_rdt;
  logic                 per_err;

  ////////////////////
  // memory/peripheral split
  ////////////////////

  lsu_demux lsu_demux_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .bus_vld (bus_vld),
    .bus_wen (bus_wen),
    .bus_adr (bus_adr),
    .bus_ben (bus_ben),
    .bus_wdt (bus_wdt),
    .bus_rdt (bus_rdt),
    .bus_err (bus_err),
    .mem_vld (mem_vld),
    .mem_wen (mem_wen),
    .mem_adr (mem_adr),
    .mem_ben (mem_ben),
    .mem_wdt (mem_wdt),
    .mem_rdt (mem_rdt),
    .pb_vld  (pb_vld),
    .pb_wen  (pb_wen),
    .pb_adr  (pb_adr),
    .pb_ben  (pb_ben),
    .pb_wdt  (pb_wdt),
    .per_rdt (per_rdt),
    .per_err (per_err)
  );

  // data ram, lower half of the address space
  data_mem data_mem_i (
    .clk     (clk),
    .mem_vld (mem_vld),
    .mem_wen (mem_wen),
    .mem_adr (mem_adr),
    .mem_ben (mem_ben),
    .mem_wdt (mem_wdt),
    .mem_rdt (mem_rdt)
  );

  // delayed request, peripherals answer in the cycle they see it
  per_req_register per_req_register_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .pb_vld  (pb_vld),
    .pb_wen  (pb_wen),
    .pb_adr  (pb_adr),
    .pb_ben  (pb_ben),
    .pb_wdt  (pb_wdt),
    .per_vld (per_vld),
    .per_wen (per_wen),
    .per_adr (per_adr),
    .per_ben (per_ben),
    .per_wdt (per_wdt)
  );

  // gpio and the empty uart slot
  // uart_rxd stays unconnected until a uart exists
  per_demux per_demux_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .per_vld     (per_vld),
    .per_wen     (per_wen),
    .per_adr     (per_adr),
    .per_ben     (per_ben),
    .per_wdt     (per_wdt),
    .per_rdt     (per_rdt),
    .per_err     (per_err),
    .gpio_drive  (gpio_drive),
    .gpio_enable (gpio_enable),
    .gpio_pins   (gpio_pins),
    .uart_txd    (uart_txd)
  );

endmodule : lsu_fabric_top

`default_nettype wire

/* test/lsu_fabric_check.sv */
// reference model and response checker for the load/store fabric testbench
// watches the outside bus, predicts every response and compares it a cycle later

`default_nettype none

`include "lsu_macros.svh"

module lsu_fabric_check (
  input  logic                    clk,
  input  logic                    rst_n,
  // bus as seen by the DUT
  input  logic                    bus_vld,
  input  logic                    bus_wen,
  input  logic [`LSU_DAW-1:0]     bus_adr,
  input  lsu_pkg::ben_t           bus_ben,
  input  lsu_pkg::data_t          bus_wdt,
  input  lsu_pkg::data_t          bus_rdt,
  input  logic                    bus_err,
  // pins
  input  logic [`LSU_GPIO_W-1:0]  gpio_drive,
  input  logic [`LSU_GPIO_W-1:0]  gpio_enable,
  input  logic [`LSU_GPIO_W-1:0]  gpio_pins,
  input  logic                    uart_txd,
  // status to the testbench top
  output logic                    fail,
  output logic [31:0]             n_issued,
  output logic [31:0]             n_checked
);

  timeunit 1ns;
  timeprecision 100ps;

  import lsu_pkg::*;

  ////////////////////
  // shadow state
  ////////////////////

  data_t        mem_sh [0:2**`LSU_MAW-1];
  data_t        drive_sh;
  data_t        oen_sh;
  // gpio outputs lag the accepted write by one cycle
  data_t        drive_lag;
  data_t        oen_lag;
  // pin synchronizer model
  data_t        pins_s1;
  data_t        pins_s2;
  // {is_read, err, rdt} per accepted transfer
  logic [33:0]  exp_q [$];
  logic [33:0]  rsp_exp;
  logic         rsp_due;
  logic         active;

  initial fail = 1'b0;

  // byte lanes of wdt replace the old word where ben is set
  function automatic data_t lane_merge(input data_t old_w, input data_t wdt, input ben_t ben);
    data_t res;
    res = old_w;
    for (int b = 0; b < `LSU_DDW/8; b++) begin
      if (ben[b]) begin
        res[8*b +: 8] = wdt[8*b +: 8];
      end
    end
    return res;
  endfunction

  // expected {err, rdt} from the address map
  function automatic logic [32:0] expect_rsp(input logic [`LSU_DAW-1:0] adr);
    if (!adr[`LSU_RGN_BIT]) begin
      return {1'b0, mem_sh[adr[`LSU_MAW+1:2]]};
    end
    // uart slot, nothing behind it
    if (adr[`LSU_PSEL_BIT]) begin
      return {1'b1, 32'h0};
    end
    case (adr[5:2])
      `LSU_GPIO_OUT: return {1'b0, drive_sh};
      `LSU_GPIO_OEN: return {1'b0, oen_sh};
      `LSU_GPIO_IN:  return {1'b0, pins_s2};
      default:       return 33'h0;
    endcase
  endfunction

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (!fail && got !== exp) begin
      $display("ERR %0.1f ns: %s got %h, expected %h", $realtime, what, got, exp);
      fail = 1'b1;
    end
  endtask

  ////////////////////
  // predict on the rising edge
  ////////////////////

  always @(posedge clk) begin
    // pins pass two flops, no reset
    pins_s2 = pins_s1;
    pins_s1 = gpio_pins;
    active  = rst_n;
    if (!rst_n) begin
      drive_sh  = '0;
      oen_sh    = '0;
      drive_lag = '0;
      oen_lag   = '0;
      rsp_due   = 1'b0;
      n_issued  = '0;
      exp_q.delete();
    end else begin
      drive_lag = drive_sh;
      oen_lag   = oen_sh;
      rsp_due   = bus_vld;
      if (bus_vld) begin
        // prediction sees the state before this transfer
        exp_q.push_back({~bus_wen, expect_rsp(bus_adr)});
        n_issued = n_issued + 1;
        if (bus_wen && !bus_adr[`LSU_RGN_BIT]) begin
          mem_sh[bus_adr[`LSU_MAW+1:2]] = lane_merge(mem_sh[bus_adr[`LSU_MAW+1:2]],
                                                     bus_wdt, bus_ben);
        end else if (bus_wen && !bus_adr[`LSU_PSEL_BIT]) begin
          // writes to IN and unmapped indices change nothing
          if (bus_adr[5:2] == `LSU_GPIO_OUT) begin
            drive_sh = lane_merge(drive_sh, bus_wdt, bus_ben);
          end else if (bus_adr[5:2] == `LSU_GPIO_OEN) begin
            oen_sh = lane_merge(oen_sh, bus_wdt, bus_ben);
          end
        end
      end
    end
  end

  ////////////////////
  // compare mid cycle
  ////////////////////

  always @(negedge clk) begin
    if (!active) begin
      n_checked = '0;
    end else begin
      check_eq("uart_txd", {31'h0, uart_txd}, 32'h1);
      check_eq("gpio_drive", gpio_drive, drive_lag);
      check_eq("gpio_enable", gpio_enable, oen_lag);
      if (rsp_due) begin
        rsp_exp = exp_q.pop_front();
        check_eq("bus_err", {31'h0, bus_err}, {31'h0, rsp_exp[32]});
        // write responses carry err only
        if (rsp_exp[33]) begin
          check_eq("bus_rdt", bus_rdt, rsp_exp[31:0]);
        end
        n_checked = n_checked + 1;
      end else begin
        check_eq("idle bus_err", {31'h0, bus_err}, 32'h0);
      end
    end
  end

endmodule : lsu_fabric_check

`default_nettype wire

/* test/lsu_fabric_tb.sv */
// testbench top for the load/store fabric, drives the outside bus and pins
// the checker module predicts and compares every response

`default_nettype none

`include "lsu_macros.svh"

module lsu_fabric_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import lsu_pkg::*;

  localparam int N_MEM = 32;
  localparam int N_MIX = 200;
  // reset, idle gaps, directed tests and traffic, rough upper bound
  localparam int EST_CYCLES  = 60 + 4*N_MEM + 80 + 2*N_MIX;
  localparam int CYCLE_LIMIT = 3*EST_CYCLES;

  logic                    clk;
  logic                    rst_n;
  logic                    bus_vld;
  logic                    bus_wen;
  logic [`LSU_DAW-1:0]     bus_adr;
  ben_t                    bus_ben;
  data_t                   bus_wdt;
  data_t                   bus_rdt;
  logic                    bus_err;
  logic [`LSU_GPIO_W-1:0]  gpio_drive;
  logic [`LSU_GPIO_W-1:0]  gpio_enable;
  logic [`LSU_GPIO_W-1:0]  gpio_pins;
  logic                    uart_txd;
  logic                    uart_rxd;
  logic                    chk_fail;
  logic [31:0]             n_issued;
  logic [31:0]             n_checked;
  int                      seed;
  int                      cyc_cnt;
  // word indices known to hold defined data
  logic [`LSU_MAW-1:0]     mem_words [N_MEM];

  lsu_fabric_top lsu_fabric_top_i (
    .clk (clk), .rst_n (rst_n),
    .bus_vld (bus_vld), .bus_wen (bus_wen), .bus_adr (bus_adr),
    .bus_ben (bus_ben), .bus_wdt (bus_wdt), .bus_rdt (bus_rdt), .bus_err (bus_err),
    .gpio_drive (gpio_drive), .gpio_enable (gpio_enable), .gpio_pins (gpio_pins),
    .uart_txd (uart_txd), .uart_rxd (uart_rxd)
  );

  lsu_fabric_check lsu_fabric_check_i (
    .clk (clk), .rst_n (rst_n),
    .bus_vld (bus_vld), .bus_wen (bus_wen), .bus_adr (bus_adr),
    .bus_ben (bus_ben), .bus_wdt (bus_wdt), .bus_rdt (bus_rdt), .bus_err (bus_err),
    .gpio_drive (gpio_drive), .gpio_enable (gpio_enable), .gpio_pins (gpio_pins),
    .uart_txd (uart_txd), .fail (chk_fail), .n_issued (n_issued), .n_checked (n_checked)
  );

  ////////////////////
  // clock and watchdogs
  ////////////////////

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    cyc_cnt = 0;
    while (cyc_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cyc_cnt++;
    end
    $display("timeout: no result after %0d clock cycles", CYCLE_LIMIT);
    $display("TEST FAILED");
    $fatal(1, "run stopped by the cycle limit");
  end

  // first mismatch ends the run
  initial begin
    wait (chk_fail === 1'b1);
    $display("TEST FAILED");
    $fatal(1, "response check mismatch");
  end

  ////////////////////
  // bus helpers
  ////////////////////

  // one transfer per rising edge
  task automatic send_xfer(input logic wen, input logic [`LSU_DAW-1:0] adr,
                           input ben_t ben, input data_t wdt);
    @(posedge clk);
    bus_vld <= 1'b1;
    bus_wen <= wen;
    bus_adr <= adr;
    bus_ben <= ben;
    bus_wdt <= wdt;
  endtask

  // stop driving, wait until every response is compared
  task automatic drain_bus();
    @(posedge clk);
    bus_vld <= 1'b0;
    bus_wen <= 1'b0;
    @(posedge clk);
    while (n_checked != n_issued) begin
      @(posedge clk);
    end
  endtask

  // random byte offset, region bit low
  function automatic logic [`LSU_DAW-1:0] mem_addr(input logic [`LSU_MAW-1:0] idx);
    return {1'b0, idx, 2'($random(seed))};
  endfunction

  // unused bits random, decode must ignore them
  function automatic logic [`LSU_DAW-1:0] gpio_addr(input logic [3:0] idx);
    return {1'b1, 7'($random(seed)), 1'b0, idx, 2'($random(seed))};
  endfunction

  function automatic logic [`LSU_DAW-1:0] uart_addr();
    return {1'b1, 7'($random(seed)), 1'b1, 4'($random(seed)), 2'($random(seed))};
  endfunction

  ////////////////////
  // test sequences
  ////////////////////

  // full word fill, partial overwrite, then read back
  task automatic mem_rw_test();
    for (int i = 0; i < N_MEM; i++) begin
      mem_words[i] = `LSU_MAW'($random(seed));
      send_xfer(1'b1, mem_addr(mem_words[i]), 4'hf, $random(seed));
      send_xfer(1'b1, mem_addr(mem_words[i]), ben_t'($random(seed)), $random(seed));
    end
    for (int i = 0; i < N_MEM; i++) begin
      send_xfer(1'b0, mem_addr(mem_words[i]), ben_t'($random(seed)), $random(seed));
    end
    drain_bus();
  endtask

  task automatic gpio_reg_test();
    send_xfer(1'b1, gpio_addr(`LSU_GPIO_OUT), 4'hf, $random(seed));
    send_xfer(1'b1, gpio_addr(`LSU_GPIO_OEN), 4'hf, $random(seed));
    send_xfer(1'b1, gpio_addr(`LSU_GPIO_OUT), 4'b0101, $random(seed));
    drain_bus();
    send_xfer(1'b0, gpio_addr(`LSU_GPIO_OUT), 4'hf, '0);
    send_xfer(1'b0, gpio_addr(`LSU_GPIO_OEN), 4'hf, '0);
    // unmapped index
    send_xfer(1'b0, gpio_addr(4'd5), 4'hf, '0);
    drain_bus();
  endtask

  // pins settle, sync delay passes, then read IN
  task automatic pin_sync_test();
    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
      gpio_pins <= $random(seed);
      repeat (3) @(posedge clk);
      send_xfer(1'b0, gpio_addr(`LSU_GPIO_IN), 4'hf, '0);
      drain_bus();
    end
  endtask

  task automatic uart_err_test();
    for (int i = 0; i < 8; i++) begin
      send_xfer(1'($random(seed)), uart_addr(), ben_t'($random(seed)), $random(seed));
    end
    drain_bus();
  endtask

  // a transfer on every cycle, all targets mixed
  task automatic mixed_traffic_test();
    int sel;
    int k;
    for (int i = 0; i < N_MIX; i++) begin
      sel = $random(seed) & 7;
      k   = $random(seed) & (N_MEM-1);
      if (i % 16 == 0) begin
        gpio_pins <= $random(seed);
      end
      if (sel < 3) begin
        send_xfer(1'b0, mem_addr(mem_words[k]), 4'hf, $random(seed));
      end else if (sel == 3) begin
        send_xfer(1'b1, mem_addr(mem_words[k]), ben_t'($random(seed)), $random(seed));
      end else if (sel < 6) begin
        send_xfer(1'b0, gpio_addr(4'($random(seed) & 3)), 4'hf, '0);
      end else if (sel == 6) begin
        send_xfer(1'b1, gpio_addr(4'($random(seed) & 3)), ben_t'($random(seed)),
                  $random(seed));
      end else begin
        send_xfer(1'($random(seed)), uart_addr(), 4'hf, $random(seed));
      end
    end
    drain_bus();
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    seed      = 32'he17d_1ca4;
    rst_n     = 1'b0;
    bus_vld   = 1'b0;
    bus_wen   = 1'b0;
    bus_adr   = '0;
    bus_ben   = '0;
    bus_wdt   = '0;
    gpio_pins = '0;
    uart_rxd  = 1'b1;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    // idle after reset, outputs at reset values
    repeat (8) @(posedge clk);
    mem_rw_test();
    gpio_reg_test();
    pin_sync_test();
    uart_err_test();
    mixed_traffic_test();
    repeat (4) @(posedge clk);
    if (chk_fail) begin
      $display("TEST FAILED");
      $fatal(1, "response check mismatch");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule : lsu_fabric_tb

`default_nettype wire

/* tb.f */
+incdir+verilog
verilog/lsu_pkg.sv
verilog/gpio_ctrl.sv
verilog/per_demux.sv
verilog/per_req_register.sv
verilog/data_mem.sv
verilog/lsu_demux.sv
verilog/lsu_fabric_top.sv
test/lsu_fabric_check.sv
test/lsu_fabric_tb.sv

/* run.sh */
#!/bin/sh
# build the load/store fabric testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module lsu_fabric_tb -o lsu_fabric_sim

status=0
out=$(./obj_dir/lsu_fabric_sim 2>&1) || status=$?
echo "$out"

if echo "$out" | grep -qx "TEST OK"; then
  exit 0
fi
echo "simulation did not pass (exit status $status)"
exit 1
